// File: logic/draw_pkg.sv
package draw_pkg;

    // Move direction encoded in key priority order
    typedef enum logic [1:0] {
        DIR_DOWN  = 2'd0,
        DIR_UP    = 2'd1,
        DIR_RIGHT = 2'd2,
        DIR_LEFT  = 2'd3
    } dir_t;

    // One bit per channel
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } colour_t;

    localparam colour_t COL_BLACK = 3'b000;
    localparam colour_t COL_WHITE = 3'b111;
    localparam colour_t COL_RED   = 3'b100;

    // 160x120 frame
    localparam logic [7:0] FRAME_W = 8'd160;
    localparam logic [6:0] FRAME_H = 7'd120;

    // Cursor coordinate wide enough for grids up to 32 cells
    localparam int COORD_W = 5;

endpackage

// File: logic/grid_if.sv
interface grid_if;
    import draw_pkg::*;

    logic [COORD_W-1:0] cell_x;    // Cell addressed by the renderer
    logic [COORD_W-1:0] cell_y;
    logic               cell_set;  // Bitmap bit of that cell
    logic [COORD_W-1:0] cursor_x;
    logic [COORD_W-1:0] cursor_y;

    // Combinational read without handshake
    modport render (
        output cell_x,
        output cell_y,
        input  cell_set,
        input  cursor_x,
        input  cursor_y
    );

    modport store (
        input  cell_x,
        input  cell_y,
        output cell_set,
        output cursor_x,
        output cursor_y
    );

endinterface

// File: logic/key_decode.sv
module key_decode #(
    parameter int MOVE_DELAY = 100000
) (
    input  logic                CLOCK_50,
    input  logic                arst_n,
    input  logic [3:0]          key,       // Active low
    output logic                move_stb,
    output draw_pkg::dir_t      move_dir
);
    import draw_pkg::*;

    localparam int CNT_W = (MOVE_DELAY > 0) ? $clog2(MOVE_DELAY + 1) : 1;

    logic [3:0]       key_q;     // Active high after sync
    logic [CNT_W-1:0] cooldown;

    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            key_q <= 4'b0000;
        end else begin
            key_q <= ~key;
        end
    end

    // Fire as soon as the cooldown has run out
    assign move_stb = (cooldown == '0) && (|key_q);

    always_comb begin
        if (key_q[0])
            move_dir = DIR_DOWN;
        else if (key_q[1])
            move_dir = DIR_UP;
        else if (key_q[2])
            move_dir = DIR_RIGHT;
        else if (key_q[3])
            move_dir = DIR_LEFT;
        else
            move_dir = DIR_DOWN;  // Don't care without strobe
    end

    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            cooldown <= '0;
        end else if (move_stb) begin
            cooldown <= CNT_W'(MOVE_DELAY);
        end else if (cooldown != '0) begin
            cooldown <= cooldown - 1'b1;
        end
    end

endmodule

// File: logic/cursor_grid.sv
module cursor_grid #(
    parameter int GRID_SIZE = 28
) (
    input  logic                          CLOCK_50,
    input  logic                          arst_n,
    input  logic                          move_stb,
    input  draw_pkg::dir_t                move_dir,
    input  logic                          draw_en,
    grid_if.store                         grid,
    output logic [draw_pkg::COORD_W-1:0] cursor_x,
    output logic [draw_pkg::COORD_W-1:0] cursor_y
);
    import draw_pkg::*;

    localparam logic [COORD_W-1:0] HOME = COORD_W'(GRID_SIZE / 2);
    localparam logic [COORD_W-1:0] LAST = COORD_W'(GRID_SIZE - 1);

    // bitmap[y][x]
    logic [GRID_SIZE-1:0][GRID_SIZE-1:0] bitmap;

    // Cursor steps one cell and drops moves off the edge
    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            cursor_x <= HOME;
            cursor_y <= HOME;
        end else if (move_stb) begin
            case (move_dir)
                DIR_DOWN: begin
                    if (cursor_y < LAST)
                        cursor_y <= cursor_y + 1'b1;
                end
                DIR_UP: begin
                    if (cursor_y > '0)
                        cursor_y <= cursor_y - 1'b1;
                end
                DIR_RIGHT: begin
                    if (cursor_x < LAST)
                        cursor_x <= cursor_x + 1'b1;
                end
                default: begin  // Left
                    if (cursor_x > '0)
                        cursor_x <= cursor_x - 1'b1;
                end
            endcase
        end
    end

    // Marks the cell under the cursor before any move on the same edge
    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            bitmap <= '0;
        end else if (draw_en) begin
            bitmap[cursor_y][cursor_x] <= 1'b1;
        end
    end

    // Renderer may address past the grid near its edges
    always_comb begin
        if (grid.cell_x <= LAST && grid.cell_y <= LAST)
            grid.cell_set = bitmap[grid.cell_y][grid.cell_x];
        else
            grid.cell_set = 1'b0;
    end

    assign grid.cursor_x = cursor_x;
    assign grid.cursor_y = cursor_y;

endmodule

// File: logic/pixel_render.sv
module pixel_render #(
    parameter int GRID_SIZE = 28,
    parameter int CELL_SIZE = 4,
    parameter int GRID_X0   = 10,
    parameter int GRID_Y0   = 10,
    parameter int PIXEL_DIV = 4
) (
    input  logic              CLOCK_50,
    input  logic              arst_n,
    grid_if.render            grid,
    output logic [7:0]        pixel_x,
    output logic [6:0]        pixel_y,
    output draw_pkg::colour_t pixel_colour,
    output logic              pixel_stb
);
    import draw_pkg::*;

    localparam int DIV_W     = (PIXEL_DIV > 1) ? $clog2(PIXEL_DIV) : 1;
    localparam int GRID_SPAN = GRID_SIZE * CELL_SIZE;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic [7:0]       scan_x;
    logic [6:0]       scan_y;
    logic [7:0]       rel_x;
    logic [6:0]       rel_y;
    logic             in_grid;
    colour_t          colour;

    assign tick = (div_cnt == DIV_W'(PIXEL_DIV - 1));

    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            scan_x  <= '0;
            scan_y  <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                if (scan_x == FRAME_W - 1'b1) begin
                    scan_x <= '0;
                    scan_y <= (scan_y == FRAME_H - 1'b1) ? '0 : scan_y + 1'b1;
                end else begin
                    scan_x <= scan_x + 1'b1;
                end
            end
        end
    end

    // Wraps below the grid origin and in_grid masks that
    assign rel_x = scan_x - 8'(GRID_X0);
    assign rel_y = scan_y - 7'(GRID_Y0);

    assign grid.cell_x = COORD_W'(rel_x / CELL_SIZE);
    assign grid.cell_y = COORD_W'(rel_y / CELL_SIZE);

    assign in_grid = (scan_x >= GRID_X0) && (scan_x < GRID_X0 + GRID_SPAN)
                  && (scan_y >= GRID_Y0) && (scan_y < GRID_Y0 + GRID_SPAN);

    always_comb begin
        if (!in_grid)
            colour = COL_BLACK;
        else if (grid.cell_x == grid.cursor_x && grid.cell_y == grid.cursor_y)
            colour = COL_RED;
        else if (grid.cell_set)
            colour = COL_BLACK;
        else
            colour = COL_WHITE;
    end

    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n)
            pixel_stb <= 1'b0;
        else
            pixel_stb <= tick;
    end

    // Pixel payload qualified by pixel_stb
    always_ff @(posedge CLOCK_50) begin
        if (tick) begin
            pixel_x      <= scan_x;
            pixel_y      <= scan_y;
            pixel_colour <= colour;
        end
    end

endmodule

// File: logic/coord_display.sv
module coord_display (
    input  logic [draw_pkg::COORD_W-1:0] cursor_x,
    input  logic [draw_pkg::COORD_W-1:0] cursor_y,
    input  logic                          draw_en,
    output logic [6:0]                    hex0,
    output logic [6:0]                    hex1,
    output logic [6:0]                    hex2,
    output logic [6:0]                    hex3,
    output logic [9:0]                    ledr
);

    // Active low segments in gfedcba order
    function automatic logic [6:0] seg7(input logic [3:0] nib);
        case (nib)
            4'h0: seg7 = 7'b1000000;
            4'h1: seg7 = 7'b1111001;
            4'h2: seg7 = 7'b0100100;
            4'h3: seg7 = 7'b0110000;
            4'h4: seg7 = 7'b0011001;
            4'h5: seg7 = 7'b0010010;
            4'h6: seg7 = 7'b0000010;
            4'h7: seg7 = 7'b1111000;
            4'h8: seg7 = 7'b0000000;
            4'h9: seg7 = 7'b0010000;
            4'hA: seg7 = 7'b0001000;
            4'hB: seg7 = 7'b0000011;
            4'hC: seg7 = 7'b1000110;
            4'hD: seg7 = 7'b0100001;
            4'hE: seg7 = 7'b0000110;
            default: seg7 = 7'b0001110;  // F
        endcase
    endfunction

    assign hex0 = seg7(cursor_x[3:0]);
    assign hex1 = seg7({3'b000, cursor_x[4]});
    assign hex2 = seg7(cursor_y[3:0]);
    assign hex3 = seg7({3'b000, cursor_y[4]});

    // ledr[9] stays dark
    assign ledr = {1'b0, draw_en, cursor_x[2:0], cursor_y};

endmodule

// File: logic/draw_pad.sv
module draw_pad #(
    parameter int GRID_SIZE  = 28,
    parameter int CELL_SIZE  = 4,
    parameter int GRID_X0    = 10,
    parameter int GRID_Y0    = 10,
    parameter int MOVE_DELAY = 100000,
    parameter int PIXEL_DIV  = 4
) (
    input  logic              CLOCK_50,
    input  logic              arst_n,
    input  logic [3:0]        key,         // Active low
    input  logic [9:0]        sw,
    output logic [6:0]        hex0,
    output logic [6:0]        hex1,
    output logic [6:0]        hex2,
    output logic [6:0]        hex3,
    output logic [9:0]        ledr,
    output logic [7:0]        pixel_x,
    output logic [6:0]        pixel_y,
    output draw_pkg::colour_t pixel_colour,
    output logic              pixel_stb
);
    import draw_pkg::*;

    logic               move_stb;
    dir_t               move_dir;
    logic [COORD_W-1:0] cursor_x;
    logic [COORD_W-1:0] cursor_y;

    grid_if grid_bus ();

    key_decode #(
        .MOVE_DELAY (MOVE_DELAY)
    ) u_key_decode (
        .CLOCK_50 (CLOCK_50),
        .arst_n   (arst_n),
        .key      (key),
        .move_stb (move_stb),
        .move_dir (move_dir)
    );

    cursor_grid #(
        .GRID_SIZE (GRID_SIZE)
    ) u_cursor_grid (
        .CLOCK_50 (CLOCK_50),
        .arst_n   (arst_n),
        .move_stb (move_stb),
        .move_dir (move_dir),
        .draw_en  (sw[1]),       // Draw switch
        .grid     (grid_bus.store),
        .cursor_x (cursor_x),
        .cursor_y (cursor_y)
    );

    pixel_render #(
        .GRID_SIZE (GRID_SIZE),
        .CELL_SIZE (CELL_SIZE),
        .GRID_X0   (GRID_X0),
        .GRID_Y0   (GRID_Y0),
        .PIXEL_DIV (PIXEL_DIV)
    ) u_pixel_render (
        .CLOCK_50     (CLOCK_50),
        .arst_n       (arst_n),
        .grid         (grid_bus.render),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .pixel_colour (pixel_colour),
        .pixel_stb    (pixel_stb)
    );

    coord_display u_coord_display (
        .cursor_x (cursor_x),
        .cursor_y (cursor_y),
        .draw_en  (sw[1]),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .ledr     (ledr)
    );

endmodule

// File: dv/clock_gen.sv
module clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic CLOCK_50,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLOCK_50 = 1'b0;
        forever #(PERIOD / 2) CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        #2 arst_n = 1'b1;  // Released like any other input
    end

endmodule

// File: dv/tb_draw_pad.sv
module tb_draw_pad;
    timeunit 1ns;
    timeprecision 100ps;
    import draw_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int MOVE_DELAY = 6;
    localparam int PIXEL_DIV  = 3;
    localparam int GRID_SIZE  = 28;
    localparam int CELL_SIZE  = 4;
    localparam int GRID_X0    = 10;
    localparam int GRID_Y0    = 10;
    localparam int SPAN       = GRID_SIZE * CELL_SIZE;
    localparam int FRAME_CYC  = 160 * 120 * PIXEL_DIV;
    localparam int GAP        = MOVE_DELAY + 2;
    localparam int HOLD       = 30;
    localparam int N_RANDOM   = 200;
    localparam int STIM_CYC   = 8 + (104 + N_RANDOM) * (GAP + 1) + 5 * (HOLD + GAP);
    localparam int TIMEOUT    = (3 * STIM_CYC) / 2 + 3 * FRAME_CYC;

    logic CLOCK_50, arst_n;
    logic [3:0] key;
    logic [9:0] sw, ledr;
    logic [6:0] hex0, hex1, hex2, hex3, pixel_y;
    logic [7:0] pixel_x;
    colour_t    pixel_colour;
    logic       pixel_stb;

    // Reference model state with the bitmap indexed [y][x]
    int m_x, m_y, m_cool, m_div, m_sx, m_sy, exp_px, exp_py;
    logic m_bm [GRID_SIZE][GRID_SIZE];
    logic [3:0] m_key_q;
    logic exp_stb;
    logic [2:0] exp_col;
    int errors = 0;
    int checks = 0;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) u_clock_gen (
        .CLOCK_50 (CLOCK_50),
        .arst_n   (arst_n)
    );

    draw_pad #(.MOVE_DELAY(MOVE_DELAY), .PIXEL_DIV(PIXEL_DIV)) UUT (
        .CLOCK_50 (CLOCK_50), .arst_n (arst_n), .key (key), .sw (sw),
        .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3), .ledr (ledr),
        .pixel_x (pixel_x), .pixel_y (pixel_y), .pixel_colour (pixel_colour),
        .pixel_stb (pixel_stb)
    );

    function automatic logic [2:0] expected_colour(input int x, input int y);
        int cx;
        int cy;
        if (x < GRID_X0 || x >= GRID_X0 + SPAN || y < GRID_Y0 || y >= GRID_Y0 + SPAN)
            return COL_BLACK;
        cx = (x - GRID_X0) / CELL_SIZE;
        cy = (y - GRID_Y0) / CELL_SIZE;
        if (cx == m_x && cy == m_y)
            return COL_RED;
        return m_bm[cy][cx] ? COL_BLACK : COL_WHITE;
    endfunction

    function automatic logic [6:0] expected_seg(input logic [3:0] nib);
        logic [6:0] lit;  // Lit segments gfedcba
        case (nib)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR t=%0t %s: expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_position(input int x, input int y);
        check_value("hex0", 32'(expected_seg(4'(x % 16))), 32'(hex0));
        check_value("hex1", 32'(expected_seg(4'(x / 16))), 32'(hex1));
        check_value("hex2", 32'(expected_seg(4'(y % 16))), 32'(hex2));
        check_value("hex3", 32'(expected_seg(4'(y / 16))), 32'(hex3));
    endtask

    // Model advances on the same edges as the DUT
    always @(posedge CLOCK_50) begin
        if (!arst_n) begin
            m_x = 14;
            m_y = 14;
            m_cool = 0;
            m_div = 0;
            m_sx = 0;
            m_sy = 0;
            m_key_q = 4'b0000;
            exp_stb = 1'b0;
            foreach (m_bm[i, j]) m_bm[i][j] = 1'b0;
        end else begin
            exp_stb = (m_div == PIXEL_DIV - 1);
            if (exp_stb) begin
                exp_px = m_sx;
                exp_py = m_sy;
                exp_col = expected_colour(m_sx, m_sy);  // Pre-edge grid and cursor
                m_sy = (m_sx == 159) ? (m_sy + 1) % 120 : m_sy;
                m_sx = (m_sx + 1) % 160;
            end
            m_div = exp_stb ? 0 : m_div + 1;
            if (sw[1])
                m_bm[m_y][m_x] = 1'b1;
            if (m_cool == 0 && m_key_q != 4'b0000) begin
                if (m_key_q[0]) m_y = (m_y < GRID_SIZE - 1) ? m_y + 1 : m_y;
                else if (m_key_q[1]) m_y = (m_y > 0) ? m_y - 1 : m_y;
                else if (m_key_q[2]) m_x = (m_x < GRID_SIZE - 1) ? m_x + 1 : m_x;
                else m_x = (m_x > 0) ? m_x - 1 : m_x;
                m_cool = MOVE_DELAY;
            end else if (m_cool != 0) begin
                m_cool--;
            end
            m_key_q = ~key;
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge CLOCK_50) begin
        if (arst_n) begin
            check_value("pixel_stb", 32'(exp_stb), 32'(pixel_stb));
            if (exp_stb) begin
                check_value("pixel_x", exp_px, 32'(pixel_x));
                check_value("pixel_y", exp_py, 32'(pixel_y));
                check_value("pixel_colour", 32'(exp_col), 32'(pixel_colour));
            end
            check_position(m_x, m_y);
            check_value("ledr", 32'({1'b0, sw[1], 3'(m_x), 5'(m_y)}), 32'(ledr));
        end
    end

    task automatic press(input logic [3:0] pressed, input int cycles);
        key = ~pressed;
        repeat (cycles) @(posedge CLOCK_50);
        #2 key = 4'hF;
        repeat (GAP) @(posedge CLOCK_50);
        #2;
    endtask

    initial begin
        key = 4'hF;
        sw  = '0;
        void'($urandom(32'heb2e_2457));
        @(posedge arst_n);
        check_position(14, 14);
        repeat (FRAME_CYC + 8) @(posedge CLOCK_50);  // Empty grid frame
        #2;
        press(4'b0001, 1);
        press(4'b0010, 1);
        press(4'b0100, 1);
        press(4'b1000, 1);
        repeat (20) press(4'b1000, 1);  // Into the left edge
        repeat (20) press(4'b0010, 1);
        repeat (30) press(4'b0100, 1);
        repeat (30) press(4'b0001, 1);
        check_position(27, 27);
        // Held keys give five strobes each
        press(4'b0010, HOLD);
        press(4'b1000, HOLD);
        press(4'b1111, HOLD);
        press(4'b0110, HOLD);
        press(4'b1100, HOLD);
        check_position(27, 22);
        repeat (N_RANDOM) begin
            sw[1] = 1'($urandom % 2);
            press(4'b0001 << ($urandom % 4), 1);
        end
        sw = '0;
        repeat (FRAME_CYC + 8) @(posedge CLOCK_50);  // Frame with the drawing
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT * CLK_PERIOD);
        $display("Timeout: the stimulus did not finish within %0d cycles", TIMEOUT);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: draw_pad.f
logic/draw_pkg.sv
logic/grid_if.sv
logic/key_decode.sv
logic/cursor_grid.sv
logic/pixel_render.sv
logic/coord_display.sv
logic/draw_pad.sv
dv/clock_gen.sv
dv/tb_draw_pad.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_draw_pad -f draw_pad.f -o sim_draw_pad
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_draw_pad)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
